/* exe_cfg.svh */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// data path width
`define EXE_WORD (32)

// reorder buffer depth, sets the rob tag width
`define EXE_ROB_ENTRY (16)

// architectural registers
`define EXE_REG_NUM (32)

// store buffer depth
`define EXE_SB_ENTRY (8)

`endif

/* isa_pkg.sv */
package isa_pkg;

  typedef enum logic [4:0] {
    OP_ADD = 5'd0,
    OP_SUB = 5'd1,
    OP_SLT = 5'd2,
    OP_AND = 5'd3,
    OP_OR  = 5'd4,
    OP_XOR = 5'd5,
    OP_BEQ = 5'd6,
    OP_BNE = 5'd7,
    OP_BLT = 5'd8,
    OP_BGE = 5'd9,
    OP_MUL = 5'd10,
    OP_LW  = 5'd11,
    OP_SW  = 5'd12
  } opcode_e;

  // bit positions in the one-hot issue vector
  localparam int FU_INT    = 0;
  localparam int FU_BRANCH = 1;
  localparam int FU_MUL    = 2;
  localparam int FU_MEM    = 3;
  localparam int NUM_FU    = 4;

  // lt and ge are signed compares
  typedef enum logic [1:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE
  } br_cond_e;

endpackage

/* exe_pkg.sv */
`include "exe_cfg.svh"

package exe_pkg;

  typedef logic [`EXE_WORD-1:0] word_t;
  typedef logic [15:0] imm_t;
  typedef logic [$clog2(`EXE_ROB_ENTRY)-1:0] rob_tag_t;
  typedef logic [$clog2(`EXE_REG_NUM)-1:0] reg_id_t;
  typedef logic [$clog2(`EXE_SB_ENTRY)-1:0] sb_tag_t;

  typedef struct packed {
    isa_pkg::opcode_e opcode;
    logic             imm_flag;
    imm_t             imm;
    word_t            src1_data;
    word_t            src2_data;
    rob_tag_t         rob_tag;
    reg_id_t          dest_id;
    sb_tag_t          sb_tag;
  } issue_pkt_t;

  // one decoded operation, seen by every unit
  typedef struct packed {
    isa_pkg::opcode_e opcode;
    word_t            operand1;
    word_t            operand2;
    word_t            imm_ext;
    word_t            src2_data;
    rob_tag_t         rob_tag;
    reg_id_t          dest_id;
    sb_tag_t          sb_tag;
  } fu_op_t;

  typedef struct packed {
    logic                 taken;
    logic [`EXE_WORD-2:0] target_hi;
  } br_view_t;

  // rob picks the view from the unit that wrote it
  typedef union packed {
    word_t    data;
    br_view_t br;
  } rob_payload_u;

  typedef struct packed {
    logic         valid;
    rob_tag_t     rob_tag;
    rob_payload_u payload;
  } rob_wb_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t rob_tag;
    word_t    data;
  } cdb_t;

  typedef struct packed {
    logic    valid;
    reg_id_t dest_id;
    word_t   data;
  } reg_wb_t;

  typedef struct packed {
    word_t    addr;
    word_t    data;
    sb_tag_t  sb_tag;
    rob_tag_t rob_tag;
  } sb_entry_t;

endpackage

/* exe_control.sv */
`timescale 1ns/100ps

module exe_control
( input                                  clk_i
 , input                                 reset_i
 , input        [isa_pkg::NUM_FU-1:0]    issue_v_i
 , input  exe_pkg::issue_pkt_t           issue_pkt_i
 , input                                 mispredict_i
 , output exe_pkg::fu_op_t               op_o
 , output logic [isa_pkg::NUM_FU-1:0]    fire_o
 , output logic [isa_pkg::NUM_FU-1:0]    out_v_o
 , output logic                          mul_stage2_en_o
 , output exe_pkg::rob_tag_t             out_rob_tag_o
 , output exe_pkg::reg_id_t              out_dest_o
);

  logic [isa_pkg::NUM_FU-1:0] v_q;
  logic                       mul_v1_q;
  exe_pkg::rob_tag_t          rob_tag_q;
  exe_pkg::reg_id_t           dest_q;

  always_comb begin
    op_o.opcode    = issue_pkt_i.opcode;
    op_o.operand1  = issue_pkt_i.src1_data;
    op_o.imm_ext   = {{($bits(exe_pkg::word_t) - $bits(exe_pkg::imm_t)){issue_pkt_i.imm[15]}},
                      issue_pkt_i.imm};
    op_o.operand2  = issue_pkt_i.imm_flag ? op_o.imm_ext : issue_pkt_i.src2_data;
    op_o.src2_data = issue_pkt_i.src2_data;
    op_o.rob_tag   = issue_pkt_i.rob_tag;
    op_o.dest_id   = issue_pkt_i.dest_id;
    op_o.sb_tag    = issue_pkt_i.sb_tag;
  end

  // flush blocks issue in the same cycle
  assign fire_o = issue_v_i & {isa_pkg::NUM_FU{~mispredict_i}};

  always_ff @(posedge clk_i) begin
    if (reset_i || mispredict_i) begin
      v_q      <= '0;
      mul_v1_q <= 1'b0;
    end else begin
      v_q              <= fire_o;
      // mul bit of v_q is the second stage
      v_q[isa_pkg::FU_MUL] <= mul_v1_q;
      mul_v1_q         <= fire_o[isa_pkg::FU_MUL];
    end
  end

  // tags for the single-cycle units, only one of them fires per cycle
  always_ff @(posedge clk_i) begin
    if (fire_o[isa_pkg::FU_INT] || fire_o[isa_pkg::FU_BRANCH] || fire_o[isa_pkg::FU_MEM]) begin
      rob_tag_q <= op_o.rob_tag;
      dest_q    <= op_o.dest_id;
    end
  end

  // results finishing during a flush are dropped too
  assign out_v_o         = v_q & {isa_pkg::NUM_FU{~mispredict_i}};
  assign mul_stage2_en_o = mul_v1_q;
  assign out_rob_tag_o   = rob_tag_q;
  assign out_dest_o      = dest_q;

  issue_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(issue_v_i));

endmodule

/* fu_int.sv */
`timescale 1ns/100ps

module fu_int
( input                          clk_i
 , input                         fire_i
 , input  exe_pkg::fu_op_t       op_i
 , output exe_pkg::word_t        result_o
);

  exe_pkg::word_t result;
  exe_pkg::word_t result_q;

  always_comb begin
    case (op_i.opcode)
      isa_pkg::OP_ADD: result = op_i.operand1 + op_i.operand2;
      isa_pkg::OP_SUB: result = op_i.operand1 - op_i.operand2;
      isa_pkg::OP_SLT: begin
        result = exe_pkg::word_t'($signed(op_i.operand1) < $signed(op_i.operand2));
      end
      isa_pkg::OP_AND: result = op_i.operand1 & op_i.operand2;
      isa_pkg::OP_OR:  result = op_i.operand1 | op_i.operand2;
      isa_pkg::OP_XOR: result = op_i.operand1 ^ op_i.operand2;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (fire_i) begin
      result_q <= result;
    end
  end

  assign result_o = result_q;

  int_opcode_a: assert property (@(posedge clk_i)
    fire_i |-> (op_i.opcode inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_SLT,
                                    isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_XOR}));

endmodule

/* fu_branch.sv */
`timescale 1ns/100ps

module fu_branch
( input                          clk_i
 , input                         fire_i
 , input  exe_pkg::fu_op_t       op_i
 , output exe_pkg::rob_payload_u payload_o
);

  isa_pkg::br_cond_e     cond;
  logic                  taken;
  exe_pkg::word_t        target;
  exe_pkg::rob_payload_u payload_q;

  always_comb begin
    case (op_i.opcode)
      isa_pkg::OP_BNE: cond = isa_pkg::BR_NE;
      isa_pkg::OP_BLT: cond = isa_pkg::BR_LT;
      isa_pkg::OP_BGE: cond = isa_pkg::BR_GE;
      default:         cond = isa_pkg::BR_EQ;
    endcase
  end

  // compare against the register value, never the imm
  always_comb begin
    case (cond)
      isa_pkg::BR_NE: taken = (op_i.operand1 != op_i.src2_data);
      isa_pkg::BR_LT: taken = ($signed(op_i.operand1) < $signed(op_i.src2_data));
      isa_pkg::BR_GE: taken = ($signed(op_i.operand1) >= $signed(op_i.src2_data));
      default:        taken = (op_i.operand1 == op_i.src2_data);
    endcase
  end

  assign target = op_i.operand1 + op_i.imm_ext;

  always_ff @(posedge clk_i) begin
    if (fire_i) begin
      payload_q.br.taken     <= taken;
      payload_q.br.target_hi <= target[$bits(exe_pkg::word_t)-1:1];
    end
  end

  assign payload_o = payload_q;

endmodule

/* fu_mult.sv */
`timescale 1ns/100ps

module fu_mult
( input                          clk_i
 , input                         fire_i
 , input                         stage2_en_i
 , input  exe_pkg::fu_op_t       op_i
 , output exe_pkg::word_t        product_o
 , output exe_pkg::rob_tag_t     rob_tag_o
 , output exe_pkg::reg_id_t      dest_o
);

  // stage one
  exe_pkg::word_t    a_q;
  exe_pkg::word_t    b_q;
  exe_pkg::rob_tag_t rob_tag1_q;
  exe_pkg::reg_id_t  dest1_q;

  // stage two
  exe_pkg::word_t    product_q;
  exe_pkg::rob_tag_t rob_tag2_q;
  exe_pkg::reg_id_t  dest2_q;

  always_ff @(posedge clk_i) begin
    if (fire_i) begin
      a_q        <= op_i.operand1;
      b_q        <= op_i.operand2;
      rob_tag1_q <= op_i.rob_tag;
      dest1_q    <= op_i.dest_id;
    end
  end

  // low word only, upper half is never kept
  always_ff @(posedge clk_i) begin
    if (stage2_en_i) begin
      product_q  <= a_q * b_q;
      rob_tag2_q <= rob_tag1_q;
      dest2_q    <= dest1_q;
    end
  end

  assign product_o = product_q;
  assign rob_tag_o = rob_tag2_q;
  assign dest_o    = dest2_q;

endmodule

/* fu_lsu.sv */
`timescale 1ns/100ps

module fu_lsu
( input                          clk_i
 , input                         fire_i
 , input  exe_pkg::fu_op_t       op_i
 , output exe_pkg::word_t        bypass_addr_o
 , output exe_pkg::sb_tag_t      bypass_sb_num_o
 , input                         sb_bypass_valid_i
 , input  exe_pkg::word_t        sb_bypass_value_i
 , output exe_pkg::word_t        mem_addr_o
 , input  exe_pkg::word_t        mem_data_i
 , output exe_pkg::word_t        load_data_o
 , output logic                  store_o
 , output exe_pkg::sb_entry_t    sb_entry_o
);

  exe_pkg::word_t     eff_addr;
  logic               is_store;
  exe_pkg::word_t     load_data_q;
  logic               store_q;
  exe_pkg::sb_entry_t sb_entry_q;

  assign eff_addr = op_i.operand1 + op_i.imm_ext;
  assign is_store = (op_i.opcode == isa_pkg::OP_SW);

  // store buffer and memory both answer in the issue cycle
  assign bypass_addr_o   = eff_addr;
  assign bypass_sb_num_o = op_i.sb_tag;
  assign mem_addr_o      = eff_addr;

  always_ff @(posedge clk_i) begin
    if (fire_i) begin
      store_q <= is_store;
      if (is_store) begin
        sb_entry_q.addr    <= eff_addr;
        sb_entry_q.data    <= op_i.src2_data;
        sb_entry_q.sb_tag  <= op_i.sb_tag;
        sb_entry_q.rob_tag <= op_i.rob_tag;
      end else begin
        // younger store in the buffer wins over memory
        load_data_q <= sb_bypass_valid_i ? sb_bypass_value_i : mem_data_i;
      end
    end
  end

  assign load_data_o = load_data_q;
  assign store_o     = store_q;
  assign sb_entry_o  = sb_entry_q;

  addr_aligned_a: assert property (@(posedge clk_i)
    fire_i |-> (eff_addr[1:0] == 2'b00));

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
( input                                              clk_i
 , input                                             reset_i
 , input        [isa_pkg::NUM_FU-1:0]                issue_v_i
 , input  exe_pkg::issue_pkt_t                       issue_pkt_i
 , input                                             mispredict_i
 , output exe_pkg::rob_wb_t [isa_pkg::NUM_FU-1:0]    rob_wb_o
 , output exe_pkg::reg_wb_t [isa_pkg::NUM_FU-1:0]    reg_wb_o
 , output exe_pkg::cdb_t    [isa_pkg::NUM_FU-1:0]    cdb_o
 // store buffer
 , output logic                                      sb_v_o
 , output exe_pkg::sb_entry_t                        sb_entry_o
 , output exe_pkg::word_t                            bypass_addr_o
 , output exe_pkg::sb_tag_t                          bypass_sb_num_o
 , input                                             sb_bypass_valid_i
 , input  exe_pkg::word_t                            sb_bypass_value_i
 // memory
 , output exe_pkg::word_t                            mem_addr_o
 , input  exe_pkg::word_t                            mem_data_i
);

  exe_pkg::fu_op_t            op;
  logic [isa_pkg::NUM_FU-1:0] fire;
  logic [isa_pkg::NUM_FU-1:0] out_v;
  logic                       mul_stage2_en;
  exe_pkg::rob_tag_t          out_rob_tag;
  exe_pkg::reg_id_t           out_dest;
  exe_pkg::word_t             int_result;
  exe_pkg::rob_payload_u      br_payload;
  exe_pkg::word_t             mul_product;
  exe_pkg::rob_tag_t          mul_rob_tag;
  exe_pkg::reg_id_t           mul_dest;
  exe_pkg::word_t             load_data;
  logic                       lsu_store;

  exe_control control
  ( .clk_i           (clk_i)
   ,.reset_i         (reset_i)
   ,.issue_v_i       (issue_v_i)
   ,.issue_pkt_i     (issue_pkt_i)
   ,.mispredict_i    (mispredict_i)
   ,.op_o            (op)
   ,.fire_o          (fire)
   ,.out_v_o         (out_v)
   ,.mul_stage2_en_o (mul_stage2_en)
   ,.out_rob_tag_o   (out_rob_tag)
   ,.out_dest_o      (out_dest)
  );

  fu_int int_fu
  ( .clk_i    (clk_i)
   ,.fire_i   (fire[isa_pkg::FU_INT])
   ,.op_i     (op)
   ,.result_o (int_result)
  );

  fu_branch branch_fu
  ( .clk_i     (clk_i)
   ,.fire_i    (fire[isa_pkg::FU_BRANCH])
   ,.op_i      (op)
   ,.payload_o (br_payload)
  );

  fu_mult mult_fu
  ( .clk_i       (clk_i)
   ,.fire_i      (fire[isa_pkg::FU_MUL])
   ,.stage2_en_i (mul_stage2_en)
   ,.op_i        (op)
   ,.product_o   (mul_product)
   ,.rob_tag_o   (mul_rob_tag)
   ,.dest_o      (mul_dest)
  );

  fu_lsu lsu_fu
  ( .clk_i             (clk_i)
   ,.fire_i            (fire[isa_pkg::FU_MEM])
   ,.op_i              (op)
   ,.bypass_addr_o     (bypass_addr_o)
   ,.bypass_sb_num_o   (bypass_sb_num_o)
   ,.sb_bypass_valid_i (sb_bypass_valid_i)
   ,.sb_bypass_value_i (sb_bypass_value_i)
   ,.mem_addr_o        (mem_addr_o)
   ,.mem_data_i        (mem_data_i)
   ,.load_data_o       (load_data)
   ,.store_o           (lsu_store)
   ,.sb_entry_o        (sb_entry_o)
  );

  // integer unit
  assign rob_wb_o[isa_pkg::FU_INT] = '{out_v[isa_pkg::FU_INT], out_rob_tag, int_result};
  assign reg_wb_o[isa_pkg::FU_INT] = '{out_v[isa_pkg::FU_INT], out_dest, int_result};
  assign cdb_o[isa_pkg::FU_INT]    = '{out_v[isa_pkg::FU_INT], out_rob_tag, int_result};

  // branch writes no register, cdb carries the taken bit
  assign rob_wb_o[isa_pkg::FU_BRANCH] = '{out_v[isa_pkg::FU_BRANCH], out_rob_tag, br_payload};
  assign reg_wb_o[isa_pkg::FU_BRANCH] = '0;
  assign cdb_o[isa_pkg::FU_BRANCH]    = '{out_v[isa_pkg::FU_BRANCH], out_rob_tag,
                                          exe_pkg::word_t'(br_payload.br.taken)};

  // multiplier
  assign rob_wb_o[isa_pkg::FU_MUL] = '{out_v[isa_pkg::FU_MUL], mul_rob_tag, mul_product};
  assign reg_wb_o[isa_pkg::FU_MUL] = '{out_v[isa_pkg::FU_MUL], mul_dest, mul_product};
  assign cdb_o[isa_pkg::FU_MUL]    = '{out_v[isa_pkg::FU_MUL], mul_rob_tag, mul_product};

  // a store only retires through the rob and the store buffer
  assign rob_wb_o[isa_pkg::FU_MEM] = '{out_v[isa_pkg::FU_MEM], out_rob_tag, load_data};
  assign reg_wb_o[isa_pkg::FU_MEM] = '{out_v[isa_pkg::FU_MEM] & ~lsu_store, out_dest, load_data};
  assign cdb_o[isa_pkg::FU_MEM]    = '{out_v[isa_pkg::FU_MEM] & ~lsu_store, out_rob_tag,
                                       load_data};
  assign sb_v_o                    = out_v[isa_pkg::FU_MEM] & lsu_store;

endmodule

/* tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD = 2
) (
  output logic clk_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

/* tb_execute_stage.sv */
`timescale 1ns/100ps
`include "exe_cfg.svh"

module tb_execute_stage;

  // directed tests take well under 200 cycles
  localparam int MAX_CYCLES = 400;

  logic                                   clk;
  logic                                   reset;
  logic [isa_pkg::NUM_FU-1:0]             issue_v;
  exe_pkg::issue_pkt_t                    issue_pkt;
  logic                                   mispredict;
  exe_pkg::rob_wb_t [isa_pkg::NUM_FU-1:0] rob_wb;
  exe_pkg::reg_wb_t [isa_pkg::NUM_FU-1:0] reg_wb;
  exe_pkg::cdb_t    [isa_pkg::NUM_FU-1:0] cdb;
  logic                                   sb_v;
  exe_pkg::sb_entry_t                     sb_entry;
  exe_pkg::word_t                         bypass_addr;
  exe_pkg::sb_tag_t                       bypass_sb_num;
  logic                                   sb_bypass_valid;
  exe_pkg::word_t                         sb_bypass_value;
  exe_pkg::word_t                         mem_addr;
  exe_pkg::word_t                         mem_data;
  exe_pkg::sb_tag_t                       sb_num_seen;

  // store buffer model, forwards on an address match
  logic                                   sb_used [`EXE_SB_ENTRY];
  exe_pkg::word_t                         sb_addr [`EXE_SB_ENTRY];
  exe_pkg::word_t                         sb_val  [`EXE_SB_ENTRY];

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     test_err_start;
  int     cycle_cnt = 0;
  string  cur_test;

  tb_clock clock_gen (.clk_o(clk));

  execute_stage dut
  ( .clk_i             (clk)
   ,.reset_i           (reset)
   ,.issue_v_i         (issue_v)
   ,.issue_pkt_i       (issue_pkt)
   ,.mispredict_i      (mispredict)
   ,.rob_wb_o          (rob_wb)
   ,.reg_wb_o          (reg_wb)
   ,.cdb_o             (cdb)
   ,.sb_v_o            (sb_v)
   ,.sb_entry_o        (sb_entry)
   ,.bypass_addr_o     (bypass_addr)
   ,.bypass_sb_num_o   (bypass_sb_num)
   ,.sb_bypass_valid_i (sb_bypass_valid)
   ,.sb_bypass_value_i (sb_bypass_value)
   ,.mem_addr_o        (mem_addr)
   ,.mem_data_i        (mem_data)
  );

  // memory answers combinationally
  assign mem_data = mem_addr ^ 32'h5a5a0000;

  always_comb begin
    sb_bypass_valid = 1'b0;
    sb_bypass_value = '0;
    for (int i = 0; i < `EXE_SB_ENTRY; i++) begin
      if (sb_used[i] && (sb_addr[i] == bypass_addr)) begin
        sb_bypass_valid = 1'b1;
        sb_bypass_value = sb_val[i];
      end
    end
  end

  // sb tag the stage shows the store buffer on a memory issue
  always @(posedge clk) begin
    if (issue_v[isa_pkg::FU_MEM]) begin
      sb_num_seen <= bypass_sb_num;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_err_start) begin
      $display("%s: pass", cur_test);
    end else begin
      $display("%s: fail, %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  task automatic clear_sb_table();
    for (int i = 0; i < `EXE_SB_ENTRY; i++) begin
      sb_used[i] = 1'b0;
      sb_addr[i] = '0;
      sb_val[i]  = '0;
    end
  endtask

  function automatic logic [isa_pkg::NUM_FU-1:0] onehot(input int fu);
    logic [isa_pkg::NUM_FU-1:0] v;
    v     = '0;
    v[fu] = 1'b1;
    return v;
  endfunction

  function automatic exe_pkg::issue_pkt_t make_pkt(
    input isa_pkg::opcode_e  op,
    input logic              imm_flag,
    input exe_pkg::imm_t     imm,
    input exe_pkg::word_t    s1,
    input exe_pkg::word_t    s2,
    input exe_pkg::rob_tag_t rob_tag,
    input exe_pkg::reg_id_t  dest,
    input exe_pkg::sb_tag_t  sb_tag
  );
    exe_pkg::issue_pkt_t p;
    p.opcode    = op;
    p.imm_flag  = imm_flag;
    p.imm       = imm;
    p.src1_data = s1;
    p.src2_data = s2;
    p.rob_tag   = rob_tag;
    p.dest_id   = dest;
    p.sb_tag    = sb_tag;
    return p;
  endfunction

  function automatic exe_pkg::word_t sext(input exe_pkg::imm_t imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic exe_pkg::word_t int_expect(
    input isa_pkg::opcode_e op,
    input exe_pkg::word_t   a,
    input exe_pkg::word_t   b
  );
    case (op)
      isa_pkg::OP_ADD: return a + b;
      isa_pkg::OP_SUB: return a - b;
      isa_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::OP_AND: return a & b;
      isa_pkg::OP_OR:  return a | b;
      isa_pkg::OP_XOR: return a ^ b;
      default:         return '0;
    endcase
  endfunction

  function automatic logic branch_taken(
    input isa_pkg::opcode_e op,
    input exe_pkg::word_t   a,
    input exe_pkg::word_t   b
  );
    case (op)
      isa_pkg::OP_BNE: return a != b;
      isa_pkg::OP_BLT: return $signed(a) < $signed(b);
      isa_pkg::OP_BGE: return $signed(a) >= $signed(b);
      default:         return a == b;
    endcase
  endfunction

  // every valid of the stage in one word
  function automatic logic [31:0] all_valids();
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < isa_pkg::NUM_FU; i++) begin
      v[i]     = rob_wb[i].valid;
      v[4 + i] = reg_wb[i].valid;
      v[8 + i] = cdb[i].valid;
    end
    v[12] = sb_v;
    return v;
  endfunction

  // leaves the testbench mid-cycle after issue, where results are stable
  task automatic issue_and_wait(input logic [isa_pkg::NUM_FU-1:0] v,
                                input exe_pkg::issue_pkt_t pkt);
    tick();
    issue_v   = v;
    issue_pkt = pkt;
    tick();
    issue_v = '0;
    #1;
  endtask

  task automatic reset_idle_test();
    begin_test("reset_idle");
    repeat (4) begin
      #1;
      check("valids", 32'd0, all_valids());
      tick();
    end
    end_test();
  endtask

  task automatic int_ops_test();
    isa_pkg::opcode_e ops [6];
    exe_pkg::word_t   a;
    exe_pkg::word_t   b;
    exe_pkg::imm_t    imm;
    exe_pkg::word_t   exp;
    int               k;
    ops[0] = isa_pkg::OP_ADD;
    ops[1] = isa_pkg::OP_SUB;
    ops[2] = isa_pkg::OP_SLT;
    ops[3] = isa_pkg::OP_AND;
    ops[4] = isa_pkg::OP_OR;
    ops[5] = isa_pkg::OP_XOR;
    begin_test("int_ops");
    k = 0;
    for (int i = 0; i < 6; i++) begin
      for (int use_imm = 0; use_imm < 2; use_imm++) begin
        a   = $random(seed);
        b   = $random(seed);
        imm = 16'($random(seed));
        exp = int_expect(ops[i], a, (use_imm != 0) ? sext(imm) : b);
        issue_and_wait(onehot(isa_pkg::FU_INT),
                       make_pkt(ops[i], 1'(use_imm), imm, a, b, 4'(k), 5'(k + 1), 3'd0));
        check("rob valid", 32'd1, 32'(rob_wb[isa_pkg::FU_INT].valid));
        check("rob tag", 32'(k % 16), 32'(rob_wb[isa_pkg::FU_INT].rob_tag));
        check("rob data", exp, rob_wb[isa_pkg::FU_INT].payload.data);
        check("reg valid", 32'd1, 32'(reg_wb[isa_pkg::FU_INT].valid));
        check("reg dest", 32'((k + 1) % 32), 32'(reg_wb[isa_pkg::FU_INT].dest_id));
        check("reg data", exp, reg_wb[isa_pkg::FU_INT].data);
        check("cdb valid", 32'd1, 32'(cdb[isa_pkg::FU_INT].valid));
        check("cdb tag", 32'(k % 16), 32'(cdb[isa_pkg::FU_INT].rob_tag));
        check("cdb data", exp, cdb[isa_pkg::FU_INT].data);
        k++;
      end
    end
    end_test();
  endtask

  task automatic branch_test();
    isa_pkg::opcode_e ops [4];
    exe_pkg::word_t   a;
    exe_pkg::word_t   b;
    exe_pkg::imm_t    imm;
    exe_pkg::word_t   tgt;
    logic             taken;
    ops[0] = isa_pkg::OP_BEQ;
    ops[1] = isa_pkg::OP_BNE;
    ops[2] = isa_pkg::OP_BLT;
    ops[3] = isa_pkg::OP_BGE;
    begin_test("branch");
    for (int i = 0; i < 4; i++) begin
      // equal operands first, then random ones
      for (int j = 0; j < 2; j++) begin
        a     = $random(seed);
        b     = (j == 0) ? a : exe_pkg::word_t'($random(seed));
        imm   = 16'($random(seed));
        tgt   = a + sext(imm);
        taken = branch_taken(ops[i], a, b);
        issue_and_wait(onehot(isa_pkg::FU_BRANCH),
                       make_pkt(ops[i], 1'b1, imm, a, b, 4'(i + 4), 5'd3, 3'd0));
        check("rob valid", 32'd1, 32'(rob_wb[isa_pkg::FU_BRANCH].valid));
        check("rob tag", 32'(i + 4), 32'(rob_wb[isa_pkg::FU_BRANCH].rob_tag));
        check("taken", 32'(taken), 32'(rob_wb[isa_pkg::FU_BRANCH].payload.br.taken));
        check("target", 32'(tgt[31:1]), 32'(rob_wb[isa_pkg::FU_BRANCH].payload.br.target_hi));
        check("reg valid", 32'd0, 32'(reg_wb[isa_pkg::FU_BRANCH].valid));
        check("cdb valid", 32'd1, 32'(cdb[isa_pkg::FU_BRANCH].valid));
        check("cdb data", 32'(taken), cdb[isa_pkg::FU_BRANCH].data);
      end
    end
    end_test();
  endtask

  task automatic mul_test();
    exe_pkg::word_t a [3];
    exe_pkg::word_t b [3];
    exe_pkg::word_t prod;
    begin_test("mul_pipeline");
    tick();
    // three back to back issues, results two cycles later
    for (int c = 0; c < 5; c++) begin
      if (c < 3) begin
        a[c]      = $random(seed);
        b[c]      = $random(seed);
        issue_v   = onehot(isa_pkg::FU_MUL);
        issue_pkt = make_pkt(isa_pkg::OP_MUL, 1'b0, 16'd0, a[c], b[c],
                             4'(8 + c), 5'(20 + c), 3'd0);
      end else begin
        issue_v = '0;
      end
      #1;
      check("valid", 32'(c >= 2), 32'(rob_wb[isa_pkg::FU_MUL].valid));
      if (c >= 2) begin
        prod = a[c - 2] * b[c - 2];
        check("rob data", prod, rob_wb[isa_pkg::FU_MUL].payload.data);
        check("rob tag", 32'(6 + c), 32'(rob_wb[isa_pkg::FU_MUL].rob_tag));
        check("reg valid", 32'd1, 32'(reg_wb[isa_pkg::FU_MUL].valid));
        check("reg dest", 32'(18 + c), 32'(reg_wb[isa_pkg::FU_MUL].dest_id));
        check("cdb data", prod, cdb[isa_pkg::FU_MUL].data);
      end
      tick();
    end
    end_test();
  endtask

  task automatic load_store_test();
    exe_pkg::word_t base;
    exe_pkg::word_t val;
    exe_pkg::word_t eff;
    exe_pkg::imm_t  imm;
    begin_test("load_store");
    clear_sb_table();
    base = $random(seed) & 32'hffff_fffc;
    imm  = 16'($random(seed)) & 16'hfffc;
    eff  = base + sext(imm);
    issue_and_wait(onehot(isa_pkg::FU_MEM),
                   make_pkt(isa_pkg::OP_LW, 1'b1, imm, base, 32'd0, 4'd2, 5'd7, 3'd1));
    check("mem load sb num", 32'd1, 32'(sb_num_seen));
    check("mem load valid", 32'd1, 32'(reg_wb[isa_pkg::FU_MEM].valid));
    check("mem load data", eff ^ 32'h5a5a0000, reg_wb[isa_pkg::FU_MEM].data);
    check("mem load dest", 32'd7, 32'(reg_wb[isa_pkg::FU_MEM].dest_id));
    check("mem load cdb", 32'd1, 32'(cdb[isa_pkg::FU_MEM].valid));
    check("mem load sb_v", 32'd0, 32'(sb_v));

    // a matching store buffer entry wins
    val        = $random(seed);
    sb_addr[3] = eff;
    sb_val[3]  = val;
    sb_used[3] = 1'b1;
    issue_and_wait(onehot(isa_pkg::FU_MEM),
                   make_pkt(isa_pkg::OP_LW, 1'b1, imm, base, 32'd0, 4'd3, 5'd8, 3'd3));
    check("fwd load sb num", 32'd3, 32'(sb_num_seen));
    check("fwd load data", val, reg_wb[isa_pkg::FU_MEM].data);
    check("fwd load tag", 32'd3, 32'(rob_wb[isa_pkg::FU_MEM].rob_tag));
    check("fwd load cdb", val, cdb[isa_pkg::FU_MEM].data);
    clear_sb_table();

    val = $random(seed);
    issue_and_wait(onehot(isa_pkg::FU_MEM),
                   make_pkt(isa_pkg::OP_SW, 1'b1, imm, base, val, 4'd9, 5'd0, 3'd5));
    check("store sb_v", 32'd1, 32'(sb_v));
    check("store addr", eff, sb_entry.addr);
    check("store data", val, sb_entry.data);
    check("store sb tag", 32'd5, 32'(sb_entry.sb_tag));
    check("store rob tag", 32'd9, 32'(sb_entry.rob_tag));
    check("store rob valid", 32'd1, 32'(rob_wb[isa_pkg::FU_MEM].valid));
    check("store reg valid", 32'd0, 32'(reg_wb[isa_pkg::FU_MEM].valid));
    check("store cdb valid", 32'd0, 32'(cdb[isa_pkg::FU_MEM].valid));
    end_test();
  endtask

  task automatic mispredict_test();
    exe_pkg::word_t a;
    exe_pkg::word_t b;
    begin_test("mispredict");
    a = $random(seed);
    b = $random(seed);
    tick();
    // int one cycle ahead of the flush, another int in the flush cycle
    issue_v   = onehot(isa_pkg::FU_INT);
    issue_pkt = make_pkt(isa_pkg::OP_ADD, 1'b0, 16'd0, a, b, 4'd1, 5'd1, 3'd0);
    tick();
    mispredict = 1'b1;
    issue_pkt  = make_pkt(isa_pkg::OP_SUB, 1'b0, 16'd0, a, b, 4'd2, 5'd2, 3'd0);
    #1;
    check("valids in flush cycle", 32'd0, all_valids());
    tick();
    mispredict = 1'b0;
    issue_v    = '0;
    #1;
    check("valids after int flush", 32'd0, all_valids());
    tick();
    // mul one cycle ahead of the flush
    issue_v   = onehot(isa_pkg::FU_MUL);
    issue_pkt = make_pkt(isa_pkg::OP_MUL, 1'b0, 16'd0, a, b, 4'd3, 5'd3, 3'd0);
    tick();
    issue_v    = '0;
    mispredict = 1'b1;
    #1;
    check("valids in mul flush", 32'd0, all_valids());
    tick();
    mispredict = 1'b0;
    #1;
    check("mul stage two dropped", 32'd0, all_valids());
    tick();
    #1;
    check("valids idle", 32'd0, all_valids());
    issue_and_wait(onehot(isa_pkg::FU_INT),
                   make_pkt(isa_pkg::OP_XOR, 1'b0, 16'd0, a, b, 4'd4, 5'd4, 3'd0));
    check("later int valid", 32'd1, 32'(rob_wb[isa_pkg::FU_INT].valid));
    check("later int data", a ^ b, reg_wb[isa_pkg::FU_INT].data);
    check("later int tag", 32'd4, 32'(cdb[isa_pkg::FU_INT].rob_tag));
    end_test();
  endtask

  initial begin
    seed       = 32'h8378da64;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    reset      = 1'b1;
    issue_v    = '0;
    issue_pkt  = '0;
    mispredict = 1'b0;
    clear_sb_table();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_idle_test();
    int_ops_test();
    branch_test();
    mul_test();
    load_store_test();
    mispredict_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
isa_pkg.sv
exe_pkg.sv
exe_control.sv
fu_int.sv
fu_branch.sv
fu_mult.sv
fu_lsu.sv
execute_stage.sv
tb_clock.sv
tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with verilator

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module tb_execute_stage -Mdir obj_dir -o tb_execute_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_execute_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
exit 1
